// File: src.f
+incdir+.
zc_isa_pkg.sv
seq_ctrl_pkg.sv
seq_decode_if.sv
zcmp_decoder.sv
stack_offset_calc.sv
rv32_instr_encoder.sv
seq_control.sv
zcmp_sequencer_top.sv
tb_clock_gen.sv
tb_zcmp_sequencer.sv

// File: tb_zcmp_sequencer.sv
// Zcmp sequencer testbench

`default_nettype none

module tb_zcmp_sequencer;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  // Generous cycle budget for all tests, about four times the expected run
  localparam int WATCHDOG_CYCLES = 5000;

  // Instruction kinds used by the model
  localparam int K_PUSH    = 0;
  localparam int K_POP     = 1;
  localparam int K_POPRET  = 2;
  localparam int K_POPRETZ = 3;
  localparam int K_MVSA    = 4;
  localparam int K_MVA     = 5;

  // RV32I major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'h03;
  localparam logic [6:0] OPC_OPIMM = 7'h13;
  localparam logic [6:0] OPC_STORE = 7'h23;
  localparam logic [6:0] OPC_JALR  = 7'h67;

  logic        clk;
  logic        rst_n;
  logic [15:0] instr_i;
  logic        instr_err_i;
  logic        valid_i;
  logic        ready_i;
  logic        halt_i;
  logic        kill_i;
  logic [31:0] instr_o;
  logic        valid_o;
  logic        ready_o;
  logic        seq_first_o;
  logic        seq_last_o;

  int          errors;
  int          checks;
  logic [31:0] lcg_state;
  // Expected expansion, at most 12 s registers plus ra, sp, a0 and ret
  logic [31:0] exp_words [0:15];

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  zcmp_sequencer_top i_zcmp_sequencer_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_i     (instr_i),
    .instr_err_i (instr_err_i),
    .valid_i     (valid_i),
    .ready_i     (ready_i),
    .halt_i      (halt_i),
    .kill_i      (kill_i),
    .instr_o     (instr_o),
    .valid_o     (valid_o),
    .ready_o     (ready_o),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0000, lcg_state[31:16]};
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // s0 and s1 are x8 and x9, s2..s11 are x18..x27
  function automatic int s_reg(input int k);
    return (k < 2) ? k + 8 : k + 16;
  endfunction

  function automatic logic [31:0] itype(input int imm, input int rs1, input int rd,
                                        input logic [2:0] f3, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  // sw rs2, imm(sp)
  function automatic logic [31:0] sw_sp(input int imm, input int rs2);
    return {imm[11:5], rs2[4:0], 5'd2, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [15:0] encode_instr(input int kind, input int rlist,
                                               input int spimm, input int r1s, input int r2s);
    logic [2:0] f;
    logic [1:0] sub;
    if (kind == K_MVSA || kind == K_MVA) begin
      sub = (kind == K_MVSA) ? 2'b01 : 2'b11;
      return {3'b101, 3'b011, r1s[2:0], sub, r2s[2:0], 2'b10};
    end
    f   = (kind == K_PUSH || kind == K_POP) ? 3'b110 : 3'b111;
    sub = (kind == K_PUSH || kind == K_POPRETZ) ? 2'b00 : 2'b10;
    return {3'b101, f, sub, rlist[3:0], spimm[1:0], 2'b10};
  endfunction

  // Fills exp_words and returns the number of words
  function automatic int build_expansion(input int kind, input int rlist, input int spimm,
                                         input int r1s, input int r2s);
    int n;
    int total;
    int cnt;
    int k;
    int rd;
    if (kind == K_MVSA) begin
      exp_words[0] = itype(0, 10, s_reg(r1s), 3'b000, OPC_OPIMM);
      exp_words[1] = itype(0, 11, s_reg(r2s), 3'b000, OPC_OPIMM);
      return 2;
    end
    if (kind == K_MVA) begin
      exp_words[0] = itype(0, s_reg(r1s), 10, 3'b000, OPC_OPIMM);
      exp_words[1] = itype(0, s_reg(r2s), 11, 3'b000, OPC_OPIMM);
      return 2;
    end
    n     = (rlist == 15) ? 12 : rlist - 4;
    total = (((n + 1) * 4 + 15) / 16) * 16 + spimm * 16;
    cnt   = 0;
    // Slot n holds ra
    for (k = 0; k <= n; k++) begin
      rd = (k == n) ? 1 : s_reg(n - 1 - k);
      if (kind == K_PUSH) begin
        exp_words[cnt] = sw_sp(-4 * (k + 1), rd);
      end else begin
        exp_words[cnt] = itype(total - 4 * (k + 1), 2, rd, 3'b010, OPC_LOAD);
      end
      cnt++;
    end
    exp_words[cnt] = itype((kind == K_PUSH) ? -total : total, 2, 2, 3'b000, OPC_OPIMM);
    cnt++;
    if (kind == K_POPRETZ) begin
      exp_words[cnt] = itype(0, 0, 10, 3'b000, OPC_OPIMM);
      cnt++;
    end
    if (kind == K_POPRET || kind == K_POPRETZ) begin
      exp_words[cnt] = itype(0, 1, 0, 3'b000, OPC_JALR);
      cnt++;
    end
    return cnt;
  endfunction

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  // Hold one instruction until its last word, with optional halt or kill
  task automatic run_seq(input logic [15:0] word, input int n, input bit rand_ready,
                         input int halt_at, input int kill_at);
    int idx;
    bit done;
    idx  = 0;
    done = 1'b0;
    while (!done) begin
      if (idx == halt_at) begin
        // Frozen, nothing emitted, nothing taken
        repeat (3) begin
          @(negedge clk);
          instr_i = word;
          valid_i = 1'b1;
          ready_i = 1'b1;
          halt_i  = 1'b1;
          #1;
          compare_bit("valid_o", valid_o, 1'b0);
          compare_bit("ready_o", ready_o, 1'b0);
        end
        halt_at = -1;
      end
      @(negedge clk);
      instr_i = word;
      valid_i = 1'b1;
      // Kill lands together with halt, which alone would keep the state
      halt_i  = (idx == kill_at);
      kill_i  = (idx == kill_at);
      ready_i = rand_ready ? ((lcg_next() % 4) != 0) : 1'b1;
      #1;
      if (kill_i) begin
        compare_bit("valid_o", valid_o, 1'b0);
        compare_bit("ready_o", ready_o, 1'b1);
        done = 1'b1;
      end else if (valid_o !== 1'b1) begin
        errors++;
        $display("Output went invalid in the middle of a sequence at word %0d", idx);
        done = 1'b1;
      end else begin
        // Held or accepted, the word must match the current slot
        compare_word("instr_o", instr_o, exp_words[idx]);
        if (ready_i) begin
          compare_bit("seq_first_o", seq_first_o, idx == 0);
          compare_bit("seq_last_o", seq_last_o, idx == n - 1);
          compare_bit("ready_o", ready_o, idx == n - 1);
          idx++;
          done = seq_last_o || (idx == n);
        end
      end
    end
    @(negedge clk);
    // Halt held over the gap after a kill, so only the kill can reset the FSM
    halt_i  = kill_i;
    kill_i  = 1'b0;
    valid_i = 1'b0;
    if (kill_at < 0 && idx != n) begin
      errors++;
      $display("Sequence for %h ended after %0d words, model has %0d", word, idx, n);
    end
  endtask

  // Instruction that must produce no output
  task automatic check_no_output(input logic [15:0] word, input bit err);
    repeat (3) begin
      @(negedge clk);
      instr_i     = word;
      instr_err_i = err;
      valid_i     = 1'b1;
      ready_i     = 1'b1;
      #1;
      compare_bit("valid_o", valid_o, 1'b0);
      compare_bit("ready_o", ready_o, 1'b1);
    end
    @(negedge clk);
    valid_i     = 1'b0;
    instr_err_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic sweep_push_pop();
    int rl;
    int sp;
    int n;
    for (rl = 4; rl <= 15; rl++) begin
      for (sp = 0; sp < 4; sp++) begin
        n = build_expansion(K_PUSH, rl, sp, 0, 0);
        run_seq(encode_instr(K_PUSH, rl, sp, 0, 0), n, 1'b0, -1, -1);
        n = build_expansion(K_POP, rl, sp, 0, 0);
        run_seq(encode_instr(K_POP, rl, sp, 0, 0), n, 1'b0, -1, -1);
      end
    end
  endtask

  task automatic popret_sequences();
    int kind;
    int i;
    int rl;
    int sp;
    int n;
    for (kind = K_POPRET; kind <= K_POPRETZ; kind++) begin
      for (i = 0; i < 4; i++) begin
        // Both ends of rlist plus two random ones
        rl = (i == 0) ? 4 : (i == 1) ? 15 : 4 + int'(lcg_next() % 12);
        sp = int'(lcg_next() % 4);
        n  = build_expansion(kind, rl, sp, 0, 0);
        run_seq(encode_instr(kind, rl, sp, 0, 0), n, 1'b0, -1, -1);
      end
    end
  endtask

  task automatic double_moves();
    int n;
    n = build_expansion(K_MVSA, 0, 0, 2, 5);
    run_seq(encode_instr(K_MVSA, 0, 0, 2, 5), n, 1'b0, -1, -1);
    n = build_expansion(K_MVSA, 0, 0, 1, 0);
    run_seq(encode_instr(K_MVSA, 0, 0, 1, 0), n, 1'b0, -1, -1);
    n = build_expansion(K_MVA, 0, 0, 0, 7);
    run_seq(encode_instr(K_MVA, 0, 0, 0, 7), n, 1'b0, -1, -1);
    // Same register twice, then a reserved rlist
    check_no_output(encode_instr(K_MVSA, 0, 0, 3, 3), 1'b0);
    check_no_output(encode_instr(K_PUSH, 3, 1, 0, 0), 1'b0);
  endtask

  task automatic random_backpressure();
    int i;
    int kind;
    int rl;
    int sp;
    int r1;
    int r2;
    int n;
    for (i = 0; i < 24; i++) begin
      kind = int'(lcg_next() % 6);
      rl   = 4 + int'(lcg_next() % 12);
      sp   = int'(lcg_next() % 4);
      r1   = int'(lcg_next() % 8);
      // r2 always differs from r1
      r2   = (r1 + 1 + int'(lcg_next() % 7)) % 8;
      n    = build_expansion(kind, rl, sp, r1, r2);
      run_seq(encode_instr(kind, rl, sp, r1, r2), n, 1'b1, -1, -1);
    end
  endtask

  task automatic halt_and_kill();
    int n;
    n = build_expansion(K_PUSH, 10, 1, 0, 0);
    run_seq(encode_instr(K_PUSH, 10, 1, 0, 0), n, 1'b0, 3, -1);
    n = build_expansion(K_POPRETZ, 15, 2, 0, 0);
    run_seq(encode_instr(K_POPRETZ, 15, 2, 0, 0), n, 1'b1, 12, -1);
    // Abandon a popret halfway, then a fresh push must start at its first word
    n = build_expansion(K_POPRET, 9, 0, 0, 0);
    run_seq(encode_instr(K_POPRET, 9, 0, 0, 0), n, 1'b0, -1, 4);
    n = build_expansion(K_PUSH, 6, 3, 0, 0);
    run_seq(encode_instr(K_PUSH, 6, 3, 0, 0), n, 1'b0, -1, -1);
  endtask

  task automatic fetch_error_blocks();
    int n;
    check_no_output(encode_instr(K_PUSH, 8, 0, 0, 0), 1'b1);
    check_no_output(encode_instr(K_MVA, 0, 0, 4, 6), 1'b1);
    // Clean instruction right after the error
    n = build_expansion(K_POP, 8, 0, 0, 0);
    run_seq(encode_instr(K_POP, 8, 0, 0, 0), n, 1'b0, -1, -1);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    errors      = 0;
    checks      = 0;
    lcg_state   = 32'h8dc1;
    instr_i     = '0;
    instr_err_i = 1'b0;
    valid_i     = 1'b0;
    ready_i     = 1'b1;
    halt_i      = 1'b0;
    kill_i      = 1'b0;
    wait (rst_n === 1'b1);
    // Idle after reset
    @(negedge clk);
    #1;
    compare_bit("valid_o", valid_o, 1'b0);
    compare_bit("seq_last_o", seq_last_o, 1'b0);
    compare_bit("ready_o", ready_o, 1'b1);
    sweep_push_pop();
    popret_sequences();
    double_moves();
    random_backpressure();
    halt_and_kill();
    fetch_error_blocks();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired before the tests completed, errors so far: %0d", errors);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock and reset

`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held low for the first cycles, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: zcmp_sequencer_top.sv
// Zcmp sequencer top level

`default_nettype none

`include "zc_consts.svh"

module zcmp_sequencer_top (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire [`ZC_INSTR_W-1:0]  instr_i,
  input  wire                    instr_err_i,
  input  wire                    valid_i,
  input  wire                    ready_i,
  input  wire                    halt_i,
  input  wire                    kill_i,
  output logic [`ZC_XLEN-1:0]    instr_o,
  output logic                   valid_o,
  output logic                   ready_o,
  output logic                   seq_first_o,
  output logic                   seq_last_o
);
  import seq_ctrl_pkg::*;

  seq_op_e              op;
  logic [3:0]           step_cnt;
  logic [`ZC_IMM_W-1:0] mem_offset;
  logic [`ZC_IMM_W-1:0] total_adj;

  // Decoded fields shared by all blocks
  seq_decode_if dec_if ();

  zcmp_decoder i_decoder (
    .instr_i (instr_i),
    .dec     (dec_if.producer)
  );

  stack_offset_calc i_offset (
    .dec          (dec_if.consumer),
    .step_cnt_i   (step_cnt),
    .op_i         (op),
    .mem_offset_o (mem_offset),
    .total_adj_o  (total_adj)
  );

  rv32_instr_encoder i_encoder (
    .dec          (dec_if.consumer),
    .op_i         (op),
    .step_cnt_i   (step_cnt),
    .mem_offset_i (mem_offset),
    .total_adj_i  (total_adj),
    .instr_o      (instr_o)
  );

  seq_control i_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec         (dec_if.consumer),
    .valid_i     (valid_i),
    .ready_i     (ready_i),
    .halt_i      (halt_i),
    .kill_i      (kill_i),
    .instr_err_i (instr_err_i),
    .valid_o     (valid_o),
    .ready_o     (ready_o),
    .seq_first_o (seq_first_o),
    .seq_last_o  (seq_last_o),
    .step_cnt_o  (step_cnt),
    .op_o        (op)
  );

endmodule

`default_nettype wire

// File: seq_control.sv
// Sequencer FSM and step counter

`default_nettype none

module seq_control (
  input  wire                   clk,
  input  wire                   rst_n,
  seq_decode_if.consumer        dec,
  input  wire                   valid_i,
  input  wire                   ready_i,
  input  wire                   halt_i,
  input  wire                   kill_i,
  input  wire                   instr_err_i,
  output logic                  valid_o,
  output logic                  ready_o,
  output logic                  seq_first_o,
  output logic                  seq_last_o,
  output logic [3:0]            step_cnt_o,
  output seq_ctrl_pkg::seq_op_e op_o
);
  import zc_isa_pkg::*;
  import seq_ctrl_pkg::*;

  seq_state_e state_q;
  seq_state_e state_n;
  logic [3:0] cnt_q;
  logic       mem_seq;
  logic       flush;

  assign mem_seq = dec.is_load || dec.is_store;

  // Output word valid only for a good, non-halted, non-killed instruction
  assign valid_o = valid_i && (dec.seq_instr != INVALID_INST) && !instr_err_i &&
                   !halt_i && !kill_i;
  // Kill wins over halt; halt alone keeps the place in the sequence
  assign flush   = (!valid_o && !halt_i) || kill_i;

  assign seq_first_o = (state_q == S_IDLE);
  assign step_cnt_o  = cnt_q;

  ////////////////////////////////////////
  // State and step counter
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= 4'd0;
    end else if (flush) begin
      state_q <= S_IDLE;
      cnt_q   <= 4'd0;
    end else if (valid_o && ready_i) begin
      // One word accepted
      state_q <= state_n;
      cnt_q   <= seq_last_o ? 4'd0 : cnt_q + 4'd1;
    end
  end

  ////////////////////////////////////////
  // Next state and operation
  ////////////////////////////////////////

  always_comb begin
    state_n    = state_q;
    op_o       = OP_SREG_MEM;
    seq_last_o = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (mem_seq) begin
          if (dec.regs_saved == 4'd0) begin
            // ra only
            op_o    = OP_RA_MEM;
            state_n = S_SP;
          end else begin
            op_o    = OP_SREG_MEM;
            state_n = (dec.regs_saved == 4'd1) ? S_RA : S_SREG;
          end
        end else begin
          op_o    = OP_MOVE_FIRST;
          state_n = S_DMOVE;
        end
      end
      S_SREG: begin
        op_o = OP_SREG_MEM;
        // Leave after the last s register
        if (cnt_q == dec.regs_saved - 4'd1) begin
          state_n = S_RA;
        end
      end
      S_RA: begin
        op_o    = OP_RA_MEM;
        state_n = S_SP;
      end
      S_SP: begin
        op_o = OP_SP_ADJ;
        if (dec.seq_instr == POPRETZ) begin
          state_n = S_A0;
        end else if (dec.seq_instr == POPRET) begin
          state_n = S_RET;
        end else begin
          // Plain push or pop ends here
          state_n    = S_IDLE;
          seq_last_o = 1'b1;
        end
      end
      S_A0: begin
        op_o    = OP_CLR_A0;
        state_n = S_RET;
      end
      S_RET: begin
        op_o       = OP_RET;
        state_n    = S_IDLE;
        seq_last_o = 1'b1;
      end
      S_DMOVE: begin
        op_o       = OP_MOVE_SECOND;
        state_n    = S_IDLE;
        seq_last_o = 1'b1;
      end
      default: state_n = S_IDLE;
    endcase
  end

  // Ready for a new input on the last accepted word, or when idle or flushed
  assign ready_o = flush || (seq_last_o && ready_i && !halt_i);

endmodule

`default_nettype wire

// File: rv32_instr_encoder.sv
// RV32I word encoder

`default_nettype none

`include "zc_consts.svh"

module rv32_instr_encoder (
  seq_decode_if.consumer              dec,
  input  wire seq_ctrl_pkg::seq_op_e  op_i,
  input  wire [3:0]                   step_cnt_i,
  input  wire [`ZC_IMM_W-1:0]         mem_offset_i,
  input  wire [`ZC_IMM_W-1:0]         total_adj_i,
  output logic [`ZC_XLEN-1:0]         instr_o
);
  import zc_isa_pkg::*;
  import seq_ctrl_pkg::*;

  logic [3:0]           sreg_idx;
  logic [4:0]           data_reg;
  logic [4:0]           mv_sreg;
  logic [4:0]           mv_areg;
  logic [`ZC_IMM_W-1:0] sp_imm;

  // s0 and s1 are x8 and x9, s2 onward start at x18
  function automatic logic [4:0] sn_to_reg(input logic [3:0] sn);
    if (sn < 4'd2) begin
      return {1'b0, sn} + 5'd8;
    end
    return {1'b0, sn} + 5'd16;
  endfunction

  // Highest s register goes first
  assign sreg_idx = dec.regs_saved - step_cnt_i - 4'd1;
  assign data_reg = (op_i == OP_RA_MEM) ? `ZC_REG_RA : sn_to_reg(sreg_idx);
  // Push lowers sp, pop raises it
  assign sp_imm   = dec.is_store ? -total_adj_i : total_adj_i;

  // First move uses r1s with a0, second r2s with a1
  assign mv_sreg = sn_to_reg((op_i == OP_MOVE_FIRST) ? {1'b0, dec.r1s} : {1'b0, dec.r2s});
  assign mv_areg = (op_i == OP_MOVE_FIRST) ? `ZC_REG_A0 : `ZC_REG_A1;

  always_comb begin
    instr_o = '0;
    case (op_i)
      OP_SREG_MEM, OP_RA_MEM: begin
        if (dec.is_store) begin
          // S-type, immediate split around rs2 and rs1
          instr_o = {mem_offset_i[11:5], data_reg, `ZC_REG_SP, 3'b010,
                     mem_offset_i[4:0], OPCODE_STORE};
        end else begin
          instr_o = {mem_offset_i, `ZC_REG_SP, 3'b010, data_reg, OPCODE_LOAD};
        end
      end
      OP_SP_ADJ: instr_o = {sp_imm, `ZC_REG_SP, 3'b000, `ZC_REG_SP, OPCODE_OPIMM};
      // addi a0, zero, 0
      OP_CLR_A0: instr_o = {12'h000, `ZC_REG_ZERO, 3'b000, `ZC_REG_A0, OPCODE_OPIMM};
      // jalr zero, 0(ra)
      OP_RET:    instr_o = {12'h000, `ZC_REG_RA, 3'b000, `ZC_REG_ZERO, OPCODE_JALR};
      OP_MOVE_FIRST, OP_MOVE_SECOND: begin
        if (dec.move_a2s) begin
          instr_o = {12'h000, mv_areg, 3'b000, mv_sreg, OPCODE_OPIMM};
        end else begin
          instr_o = {12'h000, mv_sreg, 3'b000, mv_areg, OPCODE_OPIMM};
        end
      end
      default:   instr_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: stack_offset_calc.sv
// Stack adjustment and slot offsets

`default_nettype none

`include "zc_consts.svh"

module stack_offset_calc (
  seq_decode_if.consumer                dec,
  input  wire [3:0]                     step_cnt_i,
  input  wire seq_ctrl_pkg::seq_op_e    op_i,
  output logic [`ZC_IMM_W-1:0]          mem_offset_o,
  output logic [`ZC_IMM_W-1:0]          total_adj_o
);
  import zc_isa_pkg::*;
  import seq_ctrl_pkg::*;

  logic [`ZC_IMM_W-1:0] raw_adj;
  logic [`ZC_IMM_W-1:0] raw_round;
  logic [`ZC_IMM_W-1:0] base_adj;
  logic [`ZC_IMM_W-1:0] slot_idx;
  logic [`ZC_IMM_W-1:0] slot_bytes;

  // s registers plus ra, four bytes each
  assign raw_adj   = ({{(`ZC_IMM_W-4){1'b0}}, dec.regs_saved} + 1'b1) << 2;
  // Round up to a 16-byte boundary
  assign raw_round = raw_adj + 4'd15;
  assign base_adj  = {raw_round[`ZC_IMM_W-1:4], 4'b0000};

  // Extra 16-byte blocks from spimm
  assign total_adj_o = base_adj + {{(`ZC_IMM_W-6){1'b0}}, dec.spimm, 4'b0000};

  // ra sits in the slot just below the last s register
  assign slot_idx   = (op_i == OP_RA_MEM) ? {{(`ZC_IMM_W-4){1'b0}}, dec.regs_saved}
                                          : {{(`ZC_IMM_W-4){1'b0}}, step_cnt_i};
  assign slot_bytes = (slot_idx + 1'b1) << 2;

  always_comb begin
    case (dec.seq_instr)
      // Stores go below the old sp, before it moves
      PUSH:                 mem_offset_o = -slot_bytes;
      // Loads come before sp is restored, so rewind by the total first
      POP, POPRET, POPRETZ: mem_offset_o = total_adj_o - slot_bytes;
      default:              mem_offset_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: zcmp_decoder.sv
// Zcmp instruction decoder

`default_nettype none

`include "zc_consts.svh"

module zcmp_decoder (
  input  wire [`ZC_INSTR_W-1:0] instr_i,
  seq_decode_if.producer        dec
);
  import zc_isa_pkg::*;

  logic [3:0] rlist;
  logic       rlist_ok;

  // Raw fields, shared by every Zcmp encoding
  assign rlist     = instr_i[`ZC_RLIST_HI:`ZC_RLIST_LO];
  assign dec.rlist = rlist;
  assign dec.spimm = instr_i[`ZC_SPIMM_HI:`ZC_SPIMM_LO];
  assign dec.r1s   = instr_i[`ZC_R1S_HI:`ZC_R1S_LO];
  assign dec.r2s   = instr_i[`ZC_R2S_HI:`ZC_R2S_LO];

  // rlist 0..3 are reserved encodings
  assign rlist_ok = (rlist > 4'd3);

  // 15 means ra plus s0..s11, so s10 is never saved alone
  assign dec.regs_saved = (rlist == 4'd15) ? 4'd12 :
                          (rlist_ok ? rlist - 4'd4 : 4'd0);

  ////////////////////////////////////////
  // Instruction kind
  ////////////////////////////////////////

  always_comb begin
    dec.seq_instr = INVALID_INST;
    dec.is_load   = 1'b0;
    dec.is_store  = 1'b0;
    dec.move_a2s  = 1'b0;
    // Quadrant 2, funct3 101
    if (instr_i[1:0] == 2'b10 && instr_i[15:13] == 3'b101) begin
      case (instr_i[12:10])
        3'b011: begin
          // Double move, both s registers must differ
          if (dec.r1s != dec.r2s) begin
            if (instr_i[6:5] == 2'b01) begin
              dec.seq_instr = MVSA01;
              dec.move_a2s  = 1'b1;
            end else if (instr_i[6:5] == 2'b11) begin
              dec.seq_instr = MVA01S;
            end
          end
        end
        3'b110: begin
          if (rlist_ok && instr_i[9:8] == 2'b00) begin
            dec.seq_instr = PUSH;
            dec.is_store  = 1'b1;
          end else if (rlist_ok && instr_i[9:8] == 2'b10) begin
            dec.seq_instr = POP;
            dec.is_load   = 1'b1;
          end
        end
        3'b111: begin
          // Pop followed by return, with or without a0 clear
          if (rlist_ok && instr_i[9:8] == 2'b00) begin
            dec.seq_instr = POPRETZ;
            dec.is_load   = 1'b1;
          end else if (rlist_ok && instr_i[9:8] == 2'b10) begin
            dec.seq_instr = POPRET;
            dec.is_load   = 1'b1;
          end
        end
        default: begin
          dec.seq_instr = INVALID_INST;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: seq_decode_if.sv
// Decoded Zcmp fields

`default_nettype none

interface seq_decode_if;
  import zc_isa_pkg::*;

  seq_instr_e seq_instr;
  // Push stores, pop variants load
  logic       is_load;
  logic       is_store;
  // Direction of the double move
  logic       move_a2s;
  logic [3:0] rlist;
  logic [1:0] spimm;
  // Number of s registers in the list
  logic [3:0] regs_saved;
  logic [2:0] r1s;
  logic [2:0] r2s;

  modport producer (output seq_instr, is_load, is_store, move_a2s,
                    rlist, spimm, regs_saved, r1s, r2s);
  modport consumer (input seq_instr, is_load, is_store, move_a2s,
                    rlist, spimm, regs_saved, r1s, r2s);

endinterface

`default_nettype wire

// File: seq_ctrl_pkg.sv
// Sequencer control types

`default_nettype none

package seq_ctrl_pkg;

  // Sequencer FSM states
  typedef enum logic [2:0] {
    S_IDLE, S_SREG, S_RA, S_SP, S_A0, S_RET, S_DMOVE
  } seq_state_e;

  // Operation emitted in the current cycle
  typedef enum logic [2:0] {
    OP_SREG_MEM,
    OP_RA_MEM,
    OP_SP_ADJ,
    OP_CLR_A0,
    OP_RET,
    OP_MOVE_FIRST,
    OP_MOVE_SECOND
  } seq_op_e;

endpackage

`default_nettype wire

// File: zc_isa_pkg.sv
// RISC-V ISA types for Zcmp

`default_nettype none

package zc_isa_pkg;

  ////////////////////////////////////////
  // Sequenced instruction kinds
  ////////////////////////////////////////

  // INVALID_INST covers anything not handled here
  typedef enum logic [2:0] {
    INVALID_INST = 3'd0,
    PUSH         = 3'd1,
    POP          = 3'd2,
    POPRET       = 3'd3,
    POPRETZ      = 3'd4,
    MVSA01       = 3'd5,
    MVA01S       = 3'd6
  } seq_instr_e;

  ////////////////////////////////////////
  // RV32 major opcodes
  ////////////////////////////////////////

  // Only the formats the expansion emits
  typedef enum logic [6:0] {
    // lw
    OPCODE_LOAD  = 7'h03,
    // addi
    OPCODE_OPIMM = 7'h13,
    // sw
    OPCODE_STORE = 7'h23,
    // jalr
    OPCODE_JALR  = 7'h67
  } rv_opcode_e;

endpackage

`default_nettype wire

// File: zc_consts.svh
// Zcmp sequencer constants

`ifndef ZC_CONSTS_SVH
`define ZC_CONSTS_SVH

// Data widths
`define ZC_INSTR_W 16
`define ZC_XLEN    32
`define ZC_IMM_W   12

// Architectural register numbers
`define ZC_REG_ZERO 5'd0
`define ZC_REG_RA   5'd1
`define ZC_REG_SP   5'd2
`define ZC_REG_A0   5'd10
`define ZC_REG_A1   5'd11

// Field positions inside the compressed word
`define ZC_RLIST_HI 7
`define ZC_RLIST_LO 4
`define ZC_SPIMM_HI 3
`define ZC_SPIMM_LO 2
`define ZC_R1S_HI   9
`define ZC_R1S_LO   7
`define ZC_R2S_HI   4
`define ZC_R2S_LO   2

`endif
